// ==== compile.f ====
hw/rv_isa_pkg.sv
hw/ex_ctrl_pkg.sv
hw/alu.sv
hw/regfile.sv
hw/ex_control.sv
hw/ex_stage.sv
hw/ex_top.sv
tb/clk_gen.sv
tb/ex_props.sv
tb/tb_top.sv

// ==== hw/alu.sv ====
`default_nettype none

module alu #(
    parameter int XLEN = 32
) (
    input wire [XLEN-1:0]         a,
    input wire [XLEN-1:0]         b,
    input var ex_ctrl_pkg::alu_op_e op,
    output logic [XLEN-1:0]       res
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0] shamt;

    assign shamt = b[SHW-1:0];

    always_comb begin
        case (op)
            ex_ctrl_pkg::ADD:    res = a + b;
            ex_ctrl_pkg::SUB:    res = a - b;
            ex_ctrl_pkg::SLL:    res = a << shamt;
            ex_ctrl_pkg::SLT: begin
                res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            end
            ex_ctrl_pkg::SLTU: begin
                res = {{(XLEN-1){1'b0}}, a < b};
            end
            ex_ctrl_pkg::XOR:    res = a ^ b;
            ex_ctrl_pkg::SRL:    res = a >> shamt;
            ex_ctrl_pkg::SRA:    res = $unsigned($signed(a) >>> shamt);
            ex_ctrl_pkg::OR:     res = a | b;
            ex_ctrl_pkg::AND:    res = a & b;
            ex_ctrl_pkg::PASS_B: res = b;
            default:             res = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/ex_control.sv ====
`default_nettype none

module ex_control (
    input wire [31:0]               inst,
    input wire [31:0]               mem_inst,
    input wire [31:0]               wb_inst,
    input wire [31:0]               op_a,     // Forwarded rs1
    input wire [31:0]               op_b,     // Forwarded rs2
    input wire                      br_taken,
    output ex_ctrl_pkg::fwd_sel_e   fwda,
    output ex_ctrl_pkg::fwd_sel_e   fwdb,
    output ex_ctrl_pkg::a_sel_e     asel,
    output ex_ctrl_pkg::b_sel_e     bsel,
    output ex_ctrl_pkg::csr_sel_e   csr_sel,
    output logic                    csr_en,
    output ex_ctrl_pkg::alu_op_e    alusel,
    output logic                    br_mispred,
    output logic                    br_suc,
    output logic                    flush
);

    rv_isa_pkg::inst_u ex_i;
    rv_isa_pkg::inst_u mem_i;
    rv_isa_pkg::inst_u wb_i;

    logic is_branch;
    logic br_eq;
    logic br_lt;
    logic br_cond;
    logic sr_alt;

    function automatic ex_ctrl_pkg::alu_op_e f3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: f3_op = alt ? ex_ctrl_pkg::SUB : ex_ctrl_pkg::ADD;
            rv_isa_pkg::F3_SLL:     f3_op = ex_ctrl_pkg::SLL;
            rv_isa_pkg::F3_SLT:     f3_op = ex_ctrl_pkg::SLT;
            rv_isa_pkg::F3_SLTU:    f3_op = ex_ctrl_pkg::SLTU;
            rv_isa_pkg::F3_XOR:     f3_op = ex_ctrl_pkg::XOR;
            rv_isa_pkg::F3_SR:      f3_op = alt ? ex_ctrl_pkg::SRA : ex_ctrl_pkg::SRL;
            rv_isa_pkg::F3_OR:      f3_op = ex_ctrl_pkg::OR;
            default:                f3_op = ex_ctrl_pkg::AND;
        endcase
    endfunction

    assign ex_i  = inst;
    assign mem_i = mem_inst;
    assign wb_i  = wb_inst;

    // MEM wins over WB, x0 never matches
    always_comb begin
        if (rv_isa_pkg::writes_rd(mem_i) && mem_i.r.rd == ex_i.r.rs1)
            fwda = ex_ctrl_pkg::FWD_MEM;
        else if (rv_isa_pkg::writes_rd(wb_i) && wb_i.r.rd == ex_i.r.rs1)
            fwda = ex_ctrl_pkg::FWD_WB;
        else
            fwda = ex_ctrl_pkg::FWD_NONE;

        if (rv_isa_pkg::writes_rd(mem_i) && mem_i.r.rd == ex_i.r.rs2)
            fwdb = ex_ctrl_pkg::FWD_MEM;
        else if (rv_isa_pkg::writes_rd(wb_i) && wb_i.r.rd == ex_i.r.rs2)
            fwdb = ex_ctrl_pkg::FWD_WB;
        else
            fwdb = ex_ctrl_pkg::FWD_NONE;
    end

    // Immediate shifts keep the SRA bit where funct7 sits
    assign sr_alt = (ex_i.r.funct7 == rv_isa_pkg::F7_ALT) &&
                    (ex_i.r.funct3 == rv_isa_pkg::F3_SR);

    always_comb begin
        asel   = ex_ctrl_pkg::A_REG;
        bsel   = ex_ctrl_pkg::B_IMM;
        alusel = ex_ctrl_pkg::ADD;
        case (ex_i.r.opcode)
            rv_isa_pkg::OP: begin
                bsel   = ex_ctrl_pkg::B_REG;
                alusel = f3_op(ex_i.r.funct3, ex_i.r.funct7 == rv_isa_pkg::F7_ALT);
            end
            rv_isa_pkg::OP_IMM: alusel = f3_op(ex_i.r.funct3, sr_alt);
            rv_isa_pkg::LUI:    alusel = ex_ctrl_pkg::PASS_B;
            rv_isa_pkg::AUIPC,
            rv_isa_pkg::BRANCH: asel = ex_ctrl_pkg::A_PC; // pc + imm
            default: ;
        endcase
    end

    assign is_branch = ex_i.r.opcode == rv_isa_pkg::BRANCH;
    assign br_eq     = op_a == op_b;

    always_comb begin
        // funct3[1] picks the unsigned compares
        br_lt = ex_i.r.funct3[1] ? (op_a < op_b) : ($signed(op_a) < $signed(op_b));
        case (ex_i.r.funct3)
            rv_isa_pkg::F3_BEQ:  br_cond = br_eq;
            rv_isa_pkg::F3_BNE:  br_cond = !br_eq;
            rv_isa_pkg::F3_BLT,
            rv_isa_pkg::F3_BLTU: br_cond = br_lt;
            rv_isa_pkg::F3_BGE,
            rv_isa_pkg::F3_BGEU: br_cond = !br_lt;
            default:             br_cond = 1'b0;
        endcase
    end

    assign br_mispred = is_branch && (br_cond != br_taken);
    assign br_suc     = is_branch && (br_cond == br_taken);
    assign flush      = br_mispred;

    assign csr_en = (ex_i.i.opcode == rv_isa_pkg::SYSTEM) &&
                    (ex_i.i.imm12 == rv_isa_pkg::CSR_TOHOST) &&
                    (ex_i.i.funct3 == rv_isa_pkg::F3_CSRRW ||
                     ex_i.i.funct3 == rv_isa_pkg::F3_CSRRWI);
    assign csr_sel = (ex_i.i.funct3 == rv_isa_pkg::F3_CSRRWI) ?
                     ex_ctrl_pkg::CSR_IMM : ex_ctrl_pkg::CSR_RD1;

endmodule

`default_nettype wire

// ==== hw/ex_ctrl_pkg.sv ====
`default_nettype none

package ex_ctrl_pkg;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    typedef enum logic {
        A_REG = 1'b0,
        A_PC  = 1'b1
    } a_sel_e;

    typedef enum logic {
        B_REG = 1'b0,
        B_IMM = 1'b1
    } b_sel_e;

    typedef enum logic {
        CSR_RD1 = 1'b0,
        CSR_IMM = 1'b1
    } csr_sel_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10 // LUI
    } alu_op_e;

endpackage

`default_nettype wire

// ==== hw/ex_stage.sv ====
`default_nettype none

module ex_stage #(
    parameter int XLEN = 32
) (
    input wire              clk,
    input wire              rst_n,
    input wire [XLEN-1:0]   ex_pc,
    input wire [XLEN-1:0]   ex_rd1,
    input wire [XLEN-1:0]   ex_rd2,
    input wire [XLEN-1:0]   ex_imm,
    input wire              ex_br_taken,
    input wire [31:0]       ex_inst,
    input wire [XLEN-1:0]   wb_wdata,   // Result leaving WB
    input wire [31:0]       wb_inst,
    output logic            ex_br_mispred,
    output logic            ex_flush,
    output logic [XLEN-1:0] ex_target,
    output logic            mem_br_suc,
    output logic [XLEN-1:0] mem_pc,
    output logic [XLEN-1:0] mem_alu,
    output logic [XLEN-1:0] mem_rd2,
    output logic [31:0]     mem_inst,
    output logic [XLEN-1:0] tohost
);

    ex_ctrl_pkg::fwd_sel_e fwda;
    ex_ctrl_pkg::fwd_sel_e fwdb;
    ex_ctrl_pkg::a_sel_e   asel;
    ex_ctrl_pkg::b_sel_e   bsel;
    ex_ctrl_pkg::csr_sel_e csr_sel;
    ex_ctrl_pkg::alu_op_e  alusel;

    logic            csr_en;
    logic            br_suc;
    logic [XLEN-1:0] fwd_a;
    logic [XLEN-1:0] fwd_b;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] zimm;
    logic [XLEN-1:0] csr_din;

    function automatic logic [XLEN-1:0] fwd_pick(input ex_ctrl_pkg::fwd_sel_e sel,
                                                 input logic [XLEN-1:0] reg_val,
                                                 input logic [XLEN-1:0] mem_val,
                                                 input logic [XLEN-1:0] wb_val);
        case (sel)
            ex_ctrl_pkg::FWD_MEM: fwd_pick = mem_val;
            ex_ctrl_pkg::FWD_WB:  fwd_pick = wb_val;
            default:              fwd_pick = reg_val;
        endcase
    endfunction

    assign fwd_a = fwd_pick(fwda, ex_rd1, mem_alu, wb_wdata);
    assign fwd_b = fwd_pick(fwdb, ex_rd2, mem_alu, wb_wdata);
    assign alu_a = (asel == ex_ctrl_pkg::A_PC) ? ex_pc : fwd_a;
    assign alu_b = (bsel == ex_ctrl_pkg::B_IMM) ? ex_imm : fwd_b;

    alu #(.XLEN(XLEN)) u_alu (
        .a   (alu_a),
        .b   (alu_b),
        .op  (alusel),
        .res (alu_res)
    );

    ex_control u_ctrl (
        .inst       (ex_inst),
        .mem_inst   (mem_inst),
        .wb_inst    (wb_inst),
        .op_a       (fwd_a),
        .op_b       (fwd_b),
        .br_taken   (ex_br_taken),
        .fwda       (fwda),
        .fwdb       (fwdb),
        .asel       (asel),
        .bsel       (bsel),
        .csr_sel    (csr_sel),
        .csr_en     (csr_en),
        .alusel     (alusel),
        .br_mispred (ex_br_mispred),
        .br_suc     (br_suc),
        .flush      (ex_flush)
    );

    assign ex_target = (ex_inst[6:0] == rv_isa_pkg::BRANCH) ? alu_res : '0;

    // CSRRWI zimm lives in the rs1 field
    assign zimm    = {{(XLEN-5){1'b0}}, ex_inst[19:15]};
    assign csr_din = (csr_sel == ex_ctrl_pkg::CSR_IMM) ? zimm : fwd_a;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tohost <= '0;
        end else if (csr_en) begin
            tohost <= csr_din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_pc     <= '0;
            mem_alu    <= '0;
            mem_rd2    <= '0;
            mem_br_suc <= 1'b0;
            mem_inst   <= rv_isa_pkg::NOP;
        end else begin
            mem_pc     <= ex_pc;
            mem_alu    <= alu_res;
            mem_rd2    <= fwd_b; // Store data after forwarding
            mem_br_suc <= br_suc;
            mem_inst   <= ex_inst;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ex_top.sv ====
`default_nettype none

module ex_top #(
    parameter int XLEN = 32
) (
    input wire              clk,
    input wire              rst_n,
    input wire [XLEN-1:0]   id_pc,
    input wire [31:0]       id_inst,
    input wire [XLEN-1:0]   id_imm,
    input wire              id_br_taken,
    input wire              id_valid,
    output logic            ex_br_mispred,
    output logic            ex_flush,
    output logic [XLEN-1:0] ex_target,
    output logic [XLEN-1:0] mem_pc,
    output logic [XLEN-1:0] mem_alu,
    output logic [XLEN-1:0] mem_rd2,
    output logic [31:0]     mem_inst,
    output logic            mem_br_suc,
    output logic [XLEN-1:0] tohost
);

    logic [XLEN-1:0] id_rd1;
    logic [XLEN-1:0] id_rd2;
    logic [XLEN-1:0] ex_pc;
    logic [XLEN-1:0] ex_rd1;
    logic [XLEN-1:0] ex_rd2;
    logic [XLEN-1:0] ex_imm;
    logic [31:0]     ex_inst;
    logic            ex_br_taken;
    logic [31:0]     wb_inst;
    logic [XLEN-1:0] wb_wdata;
    logic            wb_we;

    regfile #(.XLEN(XLEN)) u_rf (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (id_inst[19:15]),
        .ra2   (id_inst[24:20]),
        .rd1   (id_rd1),
        .rd2   (id_rd2),
        .we    (wb_we),
        .wa    (wb_inst[11:7]),
        .wd    (wb_wdata)
    );

    // Squash to NOP on a bubble or a mispredict in EX
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_pc       <= '0;
            ex_rd1      <= '0;
            ex_rd2      <= '0;
            ex_imm      <= '0;
            ex_br_taken <= 1'b0;
            ex_inst     <= rv_isa_pkg::NOP;
        end else if (!id_valid || ex_flush) begin
            ex_pc       <= '0;
            ex_rd1      <= '0;
            ex_rd2      <= '0;
            ex_imm      <= '0;
            ex_br_taken <= 1'b0;
            ex_inst     <= rv_isa_pkg::NOP;
        end else begin
            ex_pc       <= id_pc;
            ex_rd1      <= id_rd1;
            ex_rd2      <= id_rd2;
            ex_imm      <= id_imm;
            ex_br_taken <= id_br_taken;
            ex_inst     <= id_inst;
        end
    end

    ex_stage #(.XLEN(XLEN)) u_ex (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_pc         (ex_pc),
        .ex_rd1        (ex_rd1),
        .ex_rd2        (ex_rd2),
        .ex_imm        (ex_imm),
        .ex_br_taken   (ex_br_taken),
        .ex_inst       (ex_inst),
        .wb_wdata      (wb_wdata),
        .wb_inst       (wb_inst),
        .ex_br_mispred (ex_br_mispred),
        .ex_flush      (ex_flush),
        .ex_target     (ex_target),
        .mem_br_suc    (mem_br_suc),
        .mem_pc        (mem_pc),
        .mem_alu       (mem_alu),
        .mem_rd2       (mem_rd2),
        .mem_inst      (mem_inst),
        .tohost        (tohost)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_inst  <= rv_isa_pkg::NOP;
            wb_wdata <= '0;
        end else begin
            wb_inst  <= mem_inst;
            wb_wdata <= mem_alu;
        end
    end

    assign wb_we = rv_isa_pkg::writes_rd(wb_inst);

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`default_nettype none

module regfile #(
    parameter int XLEN = 32
) (
    input wire             clk,
    input wire             rst_n,
    input wire [4:0]       ra1,
    input wire [4:0]       ra2,
    output logic [XLEN-1:0] rd1,
    output logic [XLEN-1:0] rd2,
    input wire             we,
    input wire [4:0]       wa,
    input wire [XLEN-1:0]  wd
);

    logic [XLEN-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // Write-through so WB is visible to decode in the same cycle
    always_comb begin
        if (ra1 == 5'd0)                rd1 = '0;
        else if (we && wa == ra1)       rd1 = wd;
        else                            rd1 = regs[ra1];

        if (ra2 == 5'd0)                rd2 = '0;
        else if (we && wa == ra2)       rd2 = wd;
        else                            rd2 = regs[ra2];
    end

endmodule

`default_nettype wire

// ==== hw/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcode_e;

    // ALU funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // SRL or SRA by funct7
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRWI = 3'b101;

    localparam logic [6:0]  F7_ALT     = 7'b0100000; // SUB and SRA
    localparam logic [11:0] CSR_TOHOST = 12'h51E;
    localparam logic [31:0] NOP        = 32'h0000_0013; // addi x0, x0, 0

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_e    opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_e     opcode;
        } i;
    } inst_u;

    // Instruction writes a nonzero rd
    function automatic logic writes_rd(input inst_u w);
        writes_rd = (w.r.rd != 5'd0) &&
                    (w.r.opcode == OP || w.r.opcode == OP_IMM ||
                     w.r.opcode == LUI || w.r.opcode == AUIPC);
    endfunction

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the EX stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_top \
    -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_top > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TB FAILED" "$SIM_LOG"; then
    exit 1
fi
exit 0

// ==== tb/clk_gen.sv ====
`default_nettype none

module clk_gen #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== tb/ex_props.sv ====
`default_nettype none

module ex_props (
    input wire        clk,
    input wire        rst_n,
    input wire [31:0] inst,
    input wire        csr_en,
    input wire        br_mispred,
    input wire        br_suc,
    input wire        flush
);

    a_flush_is_mispred: assert property (
        @(posedge clk) disable iff (!rst_n) flush == br_mispred
    ) else $error("flush and br_mispred disagree");

    a_suc_mispred_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(br_suc && br_mispred)
    ) else $error("br_suc and br_mispred high together");

    // CSR writes come only from SYSTEM instructions
    a_csr_system_only: assert property (
        @(posedge clk) disable iff (!rst_n) csr_en |-> (inst[6:0] == rv_isa_pkg::SYSTEM)
    ) else $error("csr_en high for a non-SYSTEM opcode");

endmodule

`default_nettype wire

// ==== tb/ex_vectors.txt ====
# grp pc inst imm taken exp_alu exp_inst exp_mispred exp_suc exp_tohost care
# care bits: 10 mem_alu, 08 mem_inst, 04 mispred, 02 br_suc, 01 tohost
1 00000100 00500093 00000005 0 00000005 00500093 0 0 0 1E
0 00000104 FFD00113 FFFFFFFD 0 FFFFFFFD FFD00113 0 0 0 1E
0 00000108 123451B7 12345000 0 12345000 123451B7 0 0 0 1E
0 0000010C 00208233 00000000 0 00000002 00208233 0 0 0 1E
0 00000110 401202B3 00000000 0 FFFFFFFD 401202B3 0 0 0 1E
1 00000114 00119333 00000000 0 468A0000 00119333 0 0 0 1E
0 00000118 401153B3 00000000 0 FFFFFFFF 401153B3 0 0 0 1E
0 0000011C 00115433 00000000 0 07FFFFFF 00115433 0 0 0 1E
0 00000120 001124B3 00000000 0 00000001 001124B3 0 0 0 1E
0 00000124 00113533 00000000 0 00000000 00113533 0 0 0 1E
0 00000128 0011C5B3 00000000 0 12345005 0011C5B3 0 0 0 1E
0 0000012C 00316633 00000000 0 FFFFFFFD 00316633 0 0 0 1E
0 00000130 003176B3 00000000 0 12345000 003176B3 0 0 0 1E
1 00000134 00001717 00001000 0 00001134 00001717 0 0 0 1E
0 00000138 40215793 00000402 0 FFFFFFFF 40215793 0 0 0 1E
1 0000013C 00708013 00000007 0 0000000C 00708013 0 0 0 1E
0 00000140 00100833 00000000 0 00000005 00100833 0 0 0 1E
1 00000144 00108063 00000010 1 00000154 00108063 0 1 0 1E
1 00000148 00209063 00000010 0 00000158 00209063 1 0 0 1E
0 0000014C 07700A13 00000077 0 00000000 00000013 0 0 0 08
1 00000150 00114063 00000010 1 00000160 00114063 0 1 0 1E
1 00000154 00115063 00000010 1 00000164 00115063 1 0 0 1E
0 00000158 07700A13 00000077 0 00000000 00000013 0 0 0 08
1 0000015C 00116063 00000010 0 0000016C 00116063 0 1 0 1E
1 00000160 00117063 00000010 0 00000170 00117063 1 0 0 1E
0 00000164 07700A13 00000077 0 00000000 00000013 0 0 0 08
1 00000168 00208063 00000010 0 00000178 00208063 0 1 0 1E
1 0000016C 00109063 00000010 1 0000017C 00109063 1 0 0 1E
0 00000170 07700A13 00000077 0 00000000 00000013 0 0 0 08
1 00000174 00500893 00000005 0 00000005 00500893 0 0 0 1E
0 00000178 00188063 00000010 0 00000188 00188063 1 0 0 1E
0 0000017C 07700A13 00000077 0 00000000 00000013 0 0 0 08
1 00000180 000A0AB3 00000000 0 00000000 000A0AB3 0 0 0 1E
1 00000184 51E09073 00000000 0 00000000 51E09073 0 0 00000005 0F
1 00000188 02A00913 0000002A 0 0000002A 02A00913 0 0 0 1E
0 0000018C 51E91073 00000000 0 00000000 51E91073 0 0 0000002A 0F
1 00000190 51E4D073 00000000 0 00000000 51E4D073 0 0 00000009 0F

// ==== tb/tb_top.sv ====
`default_nettype none

module tb_top;

    localparam int          MAX_LINES  = 64;
    localparam int          CLK_PERIOD = 20;
    localparam logic [31:0] NOP_WORD   = 32'h0000_0013;
    localparam logic [31:0] LFSR_SEED  = 32'h0846_a197;

    logic        clk;
    logic        rst_n;
    logic [31:0] id_pc;
    logic [31:0] id_inst;
    logic [31:0] id_imm;
    logic        id_br_taken;
    logic        id_valid;
    logic        ex_br_mispred;
    logic        ex_flush;
    logic [31:0] ex_target;
    logic [31:0] mem_pc;
    logic [31:0] mem_alu;
    logic [31:0] mem_rd2;
    logic [31:0] mem_inst;
    logic        mem_br_suc;
    logic [31:0] tohost;

    // One entry per vector line
    logic [31:0] v_grp    [MAX_LINES];
    logic [31:0] v_pc     [MAX_LINES];
    logic [31:0] v_inst   [MAX_LINES];
    logic [31:0] v_imm    [MAX_LINES];
    logic [31:0] v_taken  [MAX_LINES];
    logic [31:0] v_alu    [MAX_LINES];
    logic [31:0] v_minst  [MAX_LINES];
    logic [31:0] v_mis    [MAX_LINES];
    logic [31:0] v_suc    [MAX_LINES];
    logic [31:0] v_tohost [MAX_LINES];
    logic [31:0] v_care   [MAX_LINES];
    int          v_bub    [MAX_LINES];
    bit          v_squash [MAX_LINES];

    // Register values as seen by the instruction leaving MEM
    logic [31:0] arch_regs [32];

    int          n_lines;
    int          n_bubbles;
    int          errors;
    int          checks;
    int          ex_slot;
    int          mem_slot;
    bit          loaded;
    bit          prev_mis;
    logic [31:0] lfsr;

    clk_gen #(.PERIOD(CLK_PERIOD)) u_clk (.clk(clk));

    ex_top #(.XLEN(32)) u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_pc         (id_pc),
        .id_inst       (id_inst),
        .id_imm        (id_imm),
        .id_br_taken   (id_br_taken),
        .id_valid      (id_valid),
        .ex_br_mispred (ex_br_mispred),
        .ex_flush      (ex_flush),
        .ex_target     (ex_target),
        .mem_pc        (mem_pc),
        .mem_alu       (mem_alu),
        .mem_rd2       (mem_rd2),
        .mem_inst      (mem_inst),
        .mem_br_suc    (mem_br_suc),
        .tohost        (tohost)
    );

    bind ex_control ex_props u_props (
        .clk        (tb_top.clk),
        .rst_n      (tb_top.rst_n),
        .inst       (inst),
        .csr_en     (csr_en),
        .br_mispred (br_mispred),
        .br_suc     (br_suc),
        .flush      (flush)
    );

    // Galois LFSR, taps 32,22,2,1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic load_vectors();
        int                 fd;
        int                 cnt;
        int                 guard;
        reg [8*160-1:0]     junk;
        logic [31:0]        f_grp;
        logic [31:0]        f_pc;
        logic [31:0]        f_inst;
        logic [31:0]        f_imm;
        logic [31:0]        f_tk;
        logic [31:0]        f_alu;
        logic [31:0]        f_mi;
        logic [31:0]        f_mis;
        logic [31:0]        f_suc;
        logic [31:0]        f_th;
        logic [31:0]        f_care;
        n_lines = 0;
        guard   = 0;
        fd = $fopen("tb/ex_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file tb/ex_vectors.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && n_lines < MAX_LINES && guard < 1000) begin
            guard++;
            cnt = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f_grp, f_pc, f_inst,
                          f_imm, f_tk, f_alu, f_mi, f_mis, f_suc, f_th, f_care);
            if (cnt == 11) begin
                v_grp[n_lines]    = f_grp;
                v_pc[n_lines]     = f_pc;
                v_inst[n_lines]   = f_inst;
                v_imm[n_lines]    = f_imm;
                v_taken[n_lines]  = f_tk;
                v_alu[n_lines]    = f_alu;
                v_minst[n_lines]  = f_mi;
                v_mis[n_lines]    = f_mis;
                v_suc[n_lines]    = f_suc;
                v_tohost[n_lines] = f_th;
                v_care[n_lines]   = f_care;
                n_lines++;
            end else if (cnt >= 0) begin
                cnt = $fgets(junk, fd); // comment line
            end
        end
        $fclose(fd);
        if (n_lines == 0) begin
            $display("The vector file holds no usable lines");
            errors++;
        end
    endtask

    // Bubbles only ahead of group boundaries, at most three
    task automatic plan_bubbles();
        bit draw;
        lfsr      = LFSR_SEED;
        n_bubbles = 0;
        for (int i = 0; i < n_lines; i++) begin
            v_bub[i] = 0;
            if (v_grp[i] != 0) begin
                draw = 1'b1;
                while (draw && v_bub[i] < 3) begin
                    draw = lfsr[0];
                    lfsr = lfsr_next(lfsr);
                    if (draw) v_bub[i]++;
                end
            end
            n_bubbles += v_bub[i];
        end
    endtask

    task automatic check_ex(input int i);
        if (v_squash[i]) return;
        if (v_care[i][2]) begin
            check_val("ex_br_mispred", {31'b0, ex_br_mispred}, v_mis[i]);
            check_val("ex_flush", {31'b0, ex_flush}, v_mis[i]);
        end
        if (v_inst[i][6:0] == 7'b1100011) begin
            check_val("ex_target", ex_target, v_pc[i] + v_imm[i]);
        end
    endtask

    task automatic check_mem(input int i);
        logic [6:0] opc;
        logic [4:0] rs2;
        logic [4:0] rd;
        opc = v_inst[i][6:0];
        rs2 = v_inst[i][24:20];
        rd  = v_inst[i][11:7];
        if (v_squash[i]) begin
            check_val("mem_inst", mem_inst, NOP_WORD);
            return;
        end
        check_val("mem_pc", mem_pc, v_pc[i]);
        // Only R-type and branches carry a real rs2
        if (opc == 7'b0110011 || opc == 7'b1100011) begin
            check_val("mem_rd2", mem_rd2, arch_regs[rs2]);
        end
        if (v_care[i][4]) check_val("mem_alu", mem_alu, v_alu[i]);
        if (v_care[i][3]) check_val("mem_inst", mem_inst, v_minst[i]);
        if (v_care[i][1]) check_val("mem_br_suc", {31'b0, mem_br_suc}, v_suc[i]);
        if (v_care[i][0]) check_val("tohost", tohost, v_tohost[i]);
        if (rd != 5'd0 && (opc == 7'b0110011 || opc == 7'b0010011 ||
                           opc == 7'b0110111 || opc == 7'b0010111)) begin
            arch_regs[rd] = v_alu[i];
        end
    endtask

    // Drive on the falling edge, sample at the next falling edge
    task automatic issue_slot(input int idx);
        if (idx >= 0) begin
            id_valid    = 1'b1;
            id_pc       = v_pc[idx];
            id_inst     = v_inst[idx];
            id_imm      = v_imm[idx];
            id_br_taken = v_taken[idx][0];
        end else begin
            id_valid    = 1'b0;
            id_pc       = 32'h0;
            id_inst     = NOP_WORD;
            id_imm      = 32'h0;
            id_br_taken = 1'b0;
        end
        @(posedge clk);
        @(negedge clk);
        mem_slot = ex_slot;
        ex_slot  = idx;
        if (ex_slot >= 0) check_ex(ex_slot);
        if (mem_slot >= 0) check_mem(mem_slot);
    endtask

    initial begin
        rst_n       = 1'b0;
        id_pc       = 32'h0;
        id_inst     = NOP_WORD;
        id_imm      = 32'h0;
        id_br_taken = 1'b0;
        id_valid    = 1'b0;
        errors      = 0;
        checks      = 0;
        ex_slot     = -1;
        mem_slot    = -1;
        prev_mis    = 1'b0;
        loaded      = 1'b0;
        for (int r = 0; r < 32; r++) begin
            arch_regs[r] = 32'h0;
        end
        load_vectors();
        plan_bubbles();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_val("mem_inst", mem_inst, NOP_WORD);
        check_val("mem_alu", mem_alu, 32'h0);
        check_val("tohost", tohost, 32'h0);
        check_val("ex_flush", {31'b0, ex_flush}, 32'h0);
        rst_n = 1'b1;
        for (int i = 0; i < n_lines; i++) begin
            for (int b = 0; b < v_bub[i]; b++) begin
                prev_mis = 1'b0; // the bubble takes the squash
                issue_slot(-1);
            end
            v_squash[i] = prev_mis;
            prev_mis    = v_care[i][2] && v_mis[i][0];
            issue_slot(i);
        end
        issue_slot(-1);
        issue_slot(-1);
        $display("Summary: %0d lines, %0d bubbles, %0d checks, %0d errors",
                 n_lines, n_bubbles, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #((n_lines + n_bubbles + 20) * CLK_PERIOD);
        $display("Watchdog expired before the vector stream completed");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
